//--- common/spike_cfg.svh
`ifndef SPIKE_CFG_SVH
`define SPIKE_CFG_SVH

// number of spike input channels
`define SPIKE_NUM_CH 4

// per-channel counter width
// kept small so saturation is reachable in short runs
`define SPIKE_CNT_W 8

// fast_clk cycles the counters stay frozen before the snapshot
`define SPIKE_LOCK_CYCLES 2

// width of the closed-window index
`define SPIKE_IDX_W 16

`endif

//--- common/spike_types_pkg.sv
`include "spike_cfg.svh"

package spike_types_pkg;

    // one channel's spike count within a window
    typedef logic [`SPIKE_CNT_W-1:0] count_t;

    // one bit per channel
    // spike inputs, hit strobes and saturation flags
    typedef logic [`SPIKE_NUM_CH-1:0] ch_mask_t;

    // number of windows closed since reset, wraps on overflow
    typedef logic [`SPIKE_IDX_W-1:0] window_idx_t;

endpackage

//--- common/spike_ctrl_pkg.sv
`include "spike_cfg.svh"

package spike_ctrl_pkg;

    // window sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOCK  = 2'd1,
        SNAP  = 2'd2,
        CLEAR = 2'd3
    } window_state_t;

    // lock period counter, wide enough for SPIKE_LOCK_CYCLES
    typedef logic [$clog2(`SPIKE_LOCK_CYCLES + 1)-1:0] lock_cnt_t;

endpackage

//--- common/spike_event_if.sv
interface spike_event_if;
    import spike_types_pkg::*;

    // one-cycle hit per channel, already edge detected
    ch_mask_t spike_hit;
    // counters hold during lock and snapshot
    logic     freeze;
    // counts are stable, capture them
    logic     snap;
    // zero the counters for the next window
    logic     clear;

    modport decode_mp (
        output spike_hit,
        output freeze,
        output snap,
        output clear
    );

    modport execute_mp (
        input spike_hit,
        input freeze,
        input clear
    );

    modport result_mp (
        input snap,
        input clear
    );

endinterface

//--- spike_decode/spike_decode.sv
`include "spike_cfg.svh"

module spike_decode (
    input  logic                      fast_clk,
    input  logic                      reset,
    input  logic                      slow_clk,
    input  spike_types_pkg::ch_mask_t spike,
    output logic                      window_busy,
    spike_event_if.decode_mp          ev
);
    import spike_types_pkg::*;
    import spike_ctrl_pkg::*;

    localparam lock_cnt_t LOCK_LAST = lock_cnt_t'(`SPIKE_LOCK_CYCLES - 1);

    ch_mask_t      spike_meta;
    ch_mask_t      spike_sync;
    ch_mask_t      spike_prev;
    ch_mask_t      hit_q;

    logic          slow_meta;
    logic          slow_sync;
    logic          slow_prev;
    logic          tick_q;

    window_state_t state_q;
    window_state_t state_d;
    lock_cnt_t     lock_cnt_q;

    // two-flop synchronizers, then a registered rising-edge detect
    // spike edge shows up as a hit three cycles later
    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            spike_meta <= '0;
            spike_sync <= '0;
            spike_prev <= '0;
            hit_q      <= '0;
        end else begin
            spike_meta <= spike;
            spike_sync <= spike_meta;
            spike_prev <= spike_sync;
            hit_q      <= spike_sync & ~spike_prev;
        end
    end

    // same structure for the window clock
    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            slow_meta <= 1'b0;
            slow_sync <= 1'b0;
            slow_prev <= 1'b0;
            tick_q    <= 1'b0;
        end else begin
            slow_meta <= slow_clk;
            slow_sync <= slow_meta;
            slow_prev <= slow_sync;
            tick_q    <= slow_sync & ~slow_prev;
        end
    end

    // ticks outside IDLE are dropped on purpose
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (tick_q) state_d = LOCK;
            end
            LOCK: begin
                if (lock_cnt_q == LOCK_LAST) state_d = SNAP;
            end
            SNAP:    state_d = CLEAR;
            CLEAR:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            state_q    <= IDLE;
            lock_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // counts the cycles spent in LOCK
            if (state_q == LOCK) begin
                lock_cnt_q <= lock_cnt_q + 1'b1;
            end else begin
                lock_cnt_q <= '0;
            end
        end
    end

    assign ev.spike_hit = hit_q;
    assign ev.freeze    = (state_q == LOCK) || (state_q == SNAP);
    assign ev.snap      = (state_q == SNAP);
    assign ev.clear     = (state_q == CLEAR);
    assign window_busy  = (state_q != IDLE);

    a_snap_clear_excl: assert property (
        @(posedge fast_clk) disable iff (reset)
        !(ev.snap && ev.clear)
    );

    // counters must never stay uncleared after a snapshot
    a_snap_then_clear: assert property (
        @(posedge fast_clk) disable iff (reset)
        ev.snap |=> ev.clear
    );

endmodule

//--- spike_execute/spike_execute.sv
`include "spike_cfg.svh"

module spike_execute (
    input  logic                      fast_clk,
    input  logic                      reset,
    spike_event_if.execute_mp         ev,
    output spike_types_pkg::count_t   counts [`SPIKE_NUM_CH],
    output spike_types_pkg::ch_mask_t sat
);
    import spike_types_pkg::*;

    localparam count_t CNT_MAX = '1;

    // one saturating counter per channel
    // clear wins over everything, freeze drops incoming hits
    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
                counts[ch] <= '0;
            end
            sat <= '0;
        end else if (ev.clear) begin
            for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
                counts[ch] <= '0;
            end
            sat <= '0;
        end else if (!ev.freeze) begin
            for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
                if (ev.spike_hit[ch]) begin
                    // hold at max, flag the lost spike
                    if (counts[ch] == CNT_MAX) begin
                        sat[ch] <= 1'b1;
                    end else begin
                        counts[ch] <= counts[ch] + 1'b1;
                    end
                end
            end
        end
    end

    // snapshot in result relies on these holding still
    for (genvar g = 0; g < `SPIKE_NUM_CH; g++) begin : g_chk
        a_frozen_stable: assert property (
            @(posedge fast_clk) disable iff (reset)
            ev.freeze |=> $stable(counts[g])
        );

        a_clear_zero: assert property (
            @(posedge fast_clk) disable iff (reset)
            ev.clear |=> (counts[g] == '0) && !sat[g]
        );
    end

endmodule

//--- verilog/spike_result.sv
`include "spike_cfg.svh"

module spike_result (
    input  logic                        fast_clk,
    input  logic                        reset,
    spike_event_if.result_mp            ev,
    input  spike_types_pkg::count_t     counts [`SPIKE_NUM_CH],
    input  spike_types_pkg::ch_mask_t   sat,
    output spike_types_pkg::count_t     int_cnt_out [`SPIKE_NUM_CH],
    output spike_types_pkg::ch_mask_t   sat_flags,
    output spike_types_pkg::window_idx_t window_index,
    output logic                        window_valid,
    output logic                        clear_out
);
    import spike_types_pkg::*;
    import spike_ctrl_pkg::*;

    // last sequencer strobe seen, rebuilt from snap and clear
    window_state_t strobe_q;

    // snapshot of the frozen counts, one window at a time
    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
                int_cnt_out[ch] <= '0;
            end
            sat_flags    <= '0;
            window_index <= '0;
            window_valid <= 1'b0;
            clear_out    <= 1'b0;
        end else begin
            window_valid <= ev.snap;
            clear_out    <= ev.clear;
            if (ev.snap) begin
                int_cnt_out  <= counts;
                sat_flags    <= sat;
                window_index <= window_index + 1'b1;
            end
        end
    end

    always_ff @(posedge fast_clk or posedge reset) begin
        if (reset) begin
            strobe_q <= IDLE;
        end else if (ev.snap) begin
            strobe_q <= SNAP;
        end else if (ev.clear) begin
            strobe_q <= CLEAR;
        end else begin
            strobe_q <= IDLE;
        end
    end

    a_valid_single: assert property (
        @(posedge fast_clk) disable iff (reset)
        window_valid |=> !window_valid
    );

    // a clear without a snapshot just before it would lose a window
    a_clear_after_snap: assert property (
        @(posedge fast_clk) disable iff (reset)
        ev.clear |-> strobe_q == SNAP
    );

endmodule

//--- verilog/spike_counter_top.sv
`include "spike_cfg.svh"

module spike_counter_top (
    input  logic                         fast_clk,
    input  logic                         reset,
    input  logic                         slow_clk,
    input  spike_types_pkg::ch_mask_t    spike,
    output spike_types_pkg::count_t      int_cnt_out [`SPIKE_NUM_CH],
    output spike_types_pkg::ch_mask_t    sat_flags,
    output spike_types_pkg::window_idx_t window_index,
    output logic                         window_valid,
    output logic                         clear_out,
    output logic                         window_busy
);
    import spike_types_pkg::*;

    // live counts and saturation mask, execute to result
    count_t   counts [`SPIKE_NUM_CH];
    ch_mask_t sat;

    spike_event_if ev ();

    spike_decode u_decode (
        .fast_clk    (fast_clk),
        .reset       (reset),
        .slow_clk    (slow_clk),
        .spike       (spike),
        .window_busy (window_busy),
        .ev          (ev.decode_mp)
    );

    spike_execute u_execute (
        .fast_clk (fast_clk),
        .reset    (reset),
        .ev       (ev.execute_mp),
        .counts   (counts),
        .sat      (sat)
    );

    spike_result u_result (
        .fast_clk     (fast_clk),
        .reset        (reset),
        .ev           (ev.result_mp),
        .counts       (counts),
        .sat          (sat),
        .int_cnt_out  (int_cnt_out),
        .sat_flags    (sat_flags),
        .window_index (window_index),
        .window_valid (window_valid),
        .clear_out    (clear_out)
    );

endmodule

//--- verif/spike_tb.sv
`include "spike_cfg.svh"

module spike_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import spike_types_pkg::*;

    localparam int MAX_CNT        = (1 << `SPIKE_CNT_W) - 1;
    localparam int TIMEOUT_CYCLES = 50;

    logic        fast_clk;
    logic        reset;
    logic        slow_clk;
    ch_mask_t    spike;
    count_t      int_cnt_out [`SPIKE_NUM_CH];
    ch_mask_t    sat_flags;
    window_idx_t window_index;
    logic        window_valid;
    logic        clear_out;
    logic        window_busy;

    // spikes requested per channel for the next window
    int          req_spikes [`SPIKE_NUM_CH];
    // outputs captured when window_valid is seen
    count_t      got_cnt [`SPIKE_NUM_CH];
    ch_mask_t    got_sat;
    window_idx_t got_idx;
    logic        got_busy;
    int          exp_idx;
    int          errors;
    int          checks;
    integer      seed;

    spike_counter_top dut (
        .fast_clk     (fast_clk),
        .reset        (reset),
        .slow_clk     (slow_clk),
        .spike        (spike),
        .int_cnt_out  (int_cnt_out),
        .sat_flags    (sat_flags),
        .window_index (window_index),
        .window_valid (window_valid),
        .clear_out    (clear_out),
        .window_busy  (window_busy)
    );

    initial begin
        fast_clk = 1'b0;
        forever #5 fast_clk = ~fast_clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // counter holds at its maximum
    function automatic int exp_count(input int n);
        return (n > MAX_CNT) ? MAX_CNT : n;
    endfunction

    function automatic ch_mask_t exp_sat();
        ch_mask_t mask;
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            mask[ch] = (req_spikes[ch] > MAX_CNT);
        end
        return mask;
    endfunction

    task automatic wait_idle();
        bit idle;
        idle = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES && !idle; c++) begin
            @(negedge fast_clk);
            idle = !window_busy;
        end
        if (!idle) begin
            errors++;
            $display("window_busy stayed high for %0d cycles, sequencer stuck", TIMEOUT_CYCLES);
            finish_run();
        end
    endtask

    // each spike is 2 cycles high, 2 cycles low
    task automatic pulse_spikes();
        int       most;
        ch_mask_t mask;
        most = 0;
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            if (req_spikes[ch] > most) most = req_spikes[ch];
        end
        for (int k = 0; k < most; k++) begin
            wait_idle();
            for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
                mask[ch] = (req_spikes[ch] > k);
            end
            @(posedge fast_clk);
            spike <= mask;
            repeat (2) @(posedge fast_clk);
            spike <= '0;
            @(posedge fast_clk);
        end
        // let the last hits pass the synchronizers
        repeat (6) @(posedge fast_clk);
    endtask

    task automatic close_window();
        @(posedge fast_clk);
        slow_clk <= 1'b1;
        repeat (4) @(posedge fast_clk);
        slow_clk <= 1'b0;
        repeat (4) @(posedge fast_clk);
    endtask

    task automatic wait_valid(input string name);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES && !seen; c++) begin
            @(negedge fast_clk);
            seen = window_valid;
        end
        if (!seen) begin
            errors++;
            $display("%s: window_valid did not arrive within %0d cycles", name, TIMEOUT_CYCLES);
            finish_run();
        end else begin
            got_cnt  = int_cnt_out;
            got_sat  = sat_flags;
            got_idx  = window_index;
            got_busy = window_busy;
        end
    endtask

    task automatic count_clear(input string name);
        int pulses;
        pulses = 0;
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(negedge fast_clk);
            if (clear_out) pulses++;
        end
        check({name, " clear_out pulses"}, 1, pulses);
    endtask

    // close the window and compare the snapshot with req_spikes
    task automatic run_window(input string name);
        exp_idx++;
        fork
            close_window();
            begin
                wait_valid(name);
                count_clear(name);
            end
        join
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            check($sformatf("%s ch%0d count", name, ch), exp_count(req_spikes[ch]), got_cnt[ch]);
        end
        check({name, " sat_flags"}, exp_sat(), got_sat);
        check({name, " window_index"}, exp_idx, got_idx);
        // sequencer is in CLEAR when the snapshot is valid
        check({name, " window_busy at valid"}, 1, got_busy);
        check({name, " window_busy after window"}, 0, window_busy);
    endtask

    task automatic test_reset();
        @(negedge fast_clk);
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            check($sformatf("reset ch%0d count", ch), 0, int_cnt_out[ch]);
        end
        check("reset sat_flags", 0, sat_flags);
        check("reset window_index", 0, window_index);
        check("reset window_valid", 0, window_valid);
        check("reset clear_out", 0, clear_out);
        check("reset window_busy", 0, window_busy);
    endtask

    task automatic test_basic_count();
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            req_spikes[ch] = 2 * ch + 1;
        end
        pulse_spikes();
        run_window("basic count");
    endtask

    task automatic test_clear_between();
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            req_spikes[ch] = 0;
        end
        run_window("clear between windows");
    endtask

    task automatic test_saturation();
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            req_spikes[ch] = 0;
        end
        req_spikes[0] = MAX_CNT + 5;
        req_spikes[1] = 2;
        pulse_spikes();
        run_window("saturation");
        req_spikes[0] = 0;
        req_spikes[1] = 0;
        run_window("after saturation");
    endtask

    task automatic test_random_windows();
        for (int w = 0; w < 5; w++) begin
            for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
                req_spikes[ch] = {$random(seed)} % 21;
            end
            pulse_spikes();
            run_window($sformatf("random window %0d", w));
        end
    endtask

    initial begin
        reset    = 1'b1;
        slow_clk = 1'b0;
        spike    = '0;
        errors   = 0;
        checks   = 0;
        exp_idx  = 0;
        seed     = 31949;
        for (int ch = 0; ch < `SPIKE_NUM_CH; ch++) begin
            req_spikes[ch] = 0;
        end
        repeat (2) @(posedge fast_clk);
        reset <= 1'b0;

        test_reset();
        test_basic_count();
        test_clear_between();
        test_saturation();
        test_random_windows();
        finish_run();
    end

endmodule

//--- project.f
+incdir+common
common/spike_types_pkg.sv
common/spike_ctrl_pkg.sv
common/spike_event_if.sv
spike_decode/spike_decode.sv
spike_execute/spike_execute.sv
verilog/spike_result.sv
verilog/spike_counter_top.sv
verif/spike_tb.sv

//--- Bender.yml
package:
  name: spike_counter

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/spike_types_pkg.sv
      - common/spike_ctrl_pkg.sv
      - common/spike_event_if.sv
      - spike_decode/spike_decode.sv
      - spike_execute/spike_execute.sv
      - verilog/spike_result.sv
      - verilog/spike_counter_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/spike_tb.sv
